//--- sources.f
lane_init_pkg.sv
link_state_fsm.sv
cable_prop_reader.sv
param_exchange.sv
training_os_counter.sv
lane_init_top.sv
tb_link_partner.sv
tb_lane_init.sv

//--- tb_lane_init.sv
// DUT is reset before every test
// new_sym_i is held high, so symbol alignment never stalls the FSM
module tb_lane_init
  import lane_init_pkg::*;
();

  localparam int CLK_PERIOD      = 40;
  localparam int RST_CYCLES      = 5;
  localparam int N_TESTS         = 6;
  localparam int CYCLES_PER_TEST = 800;
  localparam int TIMEOUT_CYCLES  = N_TESTS * CYCLES_PER_TEST;

  localparam logic [31:0]  CABLE_G4      = 32'h0020_0040;   // USB4 id, bit 21
  localparam logic [23:0]  PAYLOAD_G4    = 24'h04_0000;     // bit 18
  localparam link_status_t DISABLED_ONLY = '{disabled: 1'b1, training: 1'b0,
                                             ts1_gen4: 1'b0, ts2_gen4: 1'b0, cl0: 1'b0};

  logic         fsm_clk;
  logic         reset_n;
  logic         lane_disable;
  logic         disabled_min;
  logic         disconnect_sbrx;
  logic         new_sym;
  logic         train_timeout;
  logic         os_sent;
  logic         at_resp_sent;
  lane_rx_t     lane_rx;
  logic         cfg_ack;
  logic [31:0]  cfg_rdata;
  logic         at_ack;
  logic         at_err;
  logic [23:0]  at_payload;
  logic         cfg_req;
  logic [7:0]   cfg_addr;
  logic         at_req;
  os_sel_e      os_sel;
  gen_speed_e   gen_speed;
  link_status_t status;

  logic [31:0]  cable_word;
  logic [23:0]  payload;
  logic         err_first;
  int           seed;
  int           errors;
  int           failed_tests;
  int           cycle_cnt;

  // os_sel_o monitor state
  os_sel_e      exp_seq[$];
  os_sel_e      exp_sel;
  os_sel_e      sel_prev;
  logic         sel_valid;
  logic         req_prev;
  int           req_rises;
  int           req_at_data;   // AT request count when DATA first shows

  lane_init_top u_lane_init_top (
    .fsm_clk           (fsm_clk),
    .reset_n           (reset_n),
    .lane_disable_i    (lane_disable),
    .disabled_min_i    (disabled_min),
    .disconnect_sbrx_i (disconnect_sbrx),
    .new_sym_i         (new_sym),
    .train_timeout_i   (train_timeout),
    .os_sent_i         (os_sent),
    .at_resp_sent_i    (at_resp_sent),
    .lane_rx_i         (lane_rx),
    .cfg_ack_i         (cfg_ack),
    .cfg_rdata_i       (cfg_rdata),
    .at_ack_i          (at_ack),
    .at_err_i          (at_err),
    .at_payload_i      (at_payload),
    .cfg_req_o         (cfg_req),
    .cfg_addr_o        (cfg_addr),
    .at_req_o          (at_req),
    .os_sel_o          (os_sel),
    .gen_speed_o       (gen_speed),
    .status_o          (status)
  );

  tb_link_partner u_partner (
    .fsm_clk        (fsm_clk),
    .reset_n        (reset_n),
    .cable_word_i   (cable_word),
    .payload_i      (payload),
    .err_first_i    (err_first),
    .cfg_req_i      (cfg_req),
    .at_req_i       (at_req),
    .os_sel_i       (os_sel),
    .status_i       (status),
    .cfg_ack_o      (cfg_ack),
    .cfg_rdata_o    (cfg_rdata),
    .at_ack_o       (at_ack),
    .at_err_o       (at_err),
    .at_payload_o   (at_payload),
    .at_resp_sent_o (at_resp_sent),
    .os_sent_o      (os_sent),
    .lane_rx_o      (lane_rx)
  );

  initial
  begin
    fsm_clk = 1'b0;
    forever #(CLK_PERIOD / 2) fsm_clk = ~fsm_clk;
  end

  always @(posedge fsm_clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // resolved speed is the slower of cable and partner, by generation number
  function automatic gen_speed_e expected_gen(input logic [31:0] word, input logic [23:0] pay);
    int cable_num;
    int partner_num;
    int lowest;
    cable_num   = word[21] ? 4 : (word[20] ? 3 : 2);
    partner_num = pay[18] ? 4 : (pay[13] ? 3 : 2);
    lowest      = (cable_num < partner_num) ? cable_num : partner_num;
    case (lowest)
      4:       return GEN4;
      3:       return GEN3;
      default: return GEN2;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // os_sel_o monitor sampling on the falling edge
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge fsm_clk)
  begin
    if (reset_n)
    begin
      if (at_req && !req_prev)
        req_rises++;
      req_prev = at_req;
      if (!sel_valid || os_sel != sel_prev)
      begin
        if (exp_seq.size() == 0)
        begin
          $display("[ERROR] %0t os_sel_o changed to %0d after the expected sequence", $time,
                   os_sel);
          errors++;
        end
        else
        begin
          exp_sel = exp_seq.pop_front();
          if (os_sel != exp_sel)
          begin
            $display("[ERROR] %0t os_sel_o expected %0d got %0d", $time, exp_sel, os_sel);
            errors++;
          end
        end
        if (os_sel == DATA && req_at_data < 0)
          req_at_data = req_rises;
        sel_prev  = os_sel;
        sel_valid = 1'b1;
      end
    end
  end

  task step_cycle();
    @(posedge fsm_clk);
    #2;
  endtask

  task reset_dut(input logic [31:0] word, input logic [23:0] pay, input logic err_on_first);
    step_cycle();
    reset_n         = 1'b0;
    lane_disable    = 1'b0;
    disabled_min    = 1'b0;
    disconnect_sbrx = 1'b0;
    train_timeout   = 1'b0;
    cable_word      = word;
    payload         = pay;
    err_first       = err_on_first;
    sel_valid       = 1'b0;
    req_prev        = 1'b0;
    req_rises       = 0;
    req_at_data     = -1;
    exp_seq.delete();
    repeat (RST_CYCLES) @(posedge fsm_clk);
    #2;
    reset_n = 1'b1;
  endtask

  task load_sequence(input gen_speed_e gen);
    exp_seq.push_back(ZEROS);
    if (gen == GEN4)
    begin
      exp_seq.push_back(TS1_G4);
      exp_seq.push_back(TS2_G4);
      exp_seq.push_back(TS3_G4);
      exp_seq.push_back(TS4_G4);
    end
    else
    begin
      exp_seq.push_back(SLOS1);
      exp_seq.push_back(SLOS2);
      exp_seq.push_back(TS1_G23);
      exp_seq.push_back(TS2_G23);
    end
    exp_seq.push_back(DATA);
  endtask

  task bring_up();
    disabled_min = 1'b1;
    while (!status.cl0)
      step_cycle();
    step_cycle();   // lets the monitor see DATA
  endtask

  task sequence_done();
    if (exp_seq.size() != 0)
    begin
      $display("os_sel_o sequence stopped with %0d expected values never seen", exp_seq.size());
      errors++;
    end
  endtask

  task report_test(input int num, input string name, input int errs_before);
    if (errors == errs_before)
      $display("test %0d %s: ok", num, name);
    else
    begin
      $display("test %0d %s: FAIL with %0d errors", num, name, errors - errs_before);
      failed_tests++;
    end
  endtask

  task run_reset_test();
    int errs_before;
    errs_before = errors;
    reset_dut(CABLE_G4, PAYLOAD_G4, 1'b0);
    exp_seq.push_back(ZEROS);
    step_cycle();
    step_cycle();
    if (os_sel != ZEROS)
    begin
      $display("[ERROR] %0t os_sel_o expected %0d got %0d", $time, ZEROS, os_sel);
      errors++;
    end
    if (status != DISABLED_ONLY)
    begin
      $display("[ERROR] %0t status_o expected %b got %b", $time, DISABLED_ONLY, status);
      errors++;
    end
    if (cfg_req !== 1'b0 || at_req !== 1'b0)
    begin
      $display("[ERROR] %0t cfg_req_o/at_req_o expected 0/0 got %b/%b", $time, cfg_req, at_req);
      errors++;
    end
    if (cfg_addr != 8'd18)
    begin
      $display("[ERROR] %0t cfg_addr_o expected 18 got %0d", $time, cfg_addr);
      errors++;
    end
    sequence_done();
    report_test(1, "reset state", errs_before);
  endtask

  task run_gen4_test();
    int errs_before;
    errs_before = errors;
    reset_dut(CABLE_G4, PAYLOAD_G4, 1'b0);
    load_sequence(GEN4);
    bring_up();
    if (gen_speed != GEN4)
    begin
      $display("[ERROR] %0t gen_speed_o expected %0d got %0d", $time, GEN4, gen_speed);
      errors++;
    end
    if (req_rises != 1)
    begin
      $display("[ERROR] %0t at_req_o rises expected 1 got %0d", $time, req_rises);
      errors++;
    end
    sequence_done();
    report_test(2, "gen 4 bring-up", errs_before);
  endtask

  task run_random_test();
    int          errs_before;
    logic [31:0] word;
    logic [23:0] pay;
    gen_speed_e  exp_gen;
    errs_before = errors;
    exp_gen     = GEN4;
    // draw until one side is below gen 4 so the SLOS sequence runs
    while (exp_gen == GEN4)
    begin
      word      = $random(seed);
      word[7:0] = 8'h40;
      pay       = 24'($random(seed));
      exp_gen   = expected_gen(word, pay);
    end
    reset_dut(word, pay, 1'b0);
    load_sequence(exp_gen);
    bring_up();
    if (gen_speed != exp_gen)
    begin
      $display("[ERROR] %0t gen_speed_o expected %0d got %0d", $time, exp_gen, gen_speed);
      errors++;
    end
    sequence_done();
    report_test(3, $sformatf("random generations, speed code %0d", exp_gen), errs_before);
  endtask

  task run_at_error_test();
    int errs_before;
    errs_before = errors;
    reset_dut(CABLE_G4, PAYLOAD_G4, 1'b1);
    load_sequence(GEN4);
    bring_up();
    if (req_rises != 2)
    begin
      $display("[ERROR] %0t at_req_o rises expected 2 got %0d", $time, req_rises);
      errors++;
    end
    sequence_done();
    report_test(4, "AT error retry", errs_before);
  endtask

  task run_disconnect_test();
    int errs_before;
    errs_before = errors;
    reset_dut(CABLE_G4, PAYLOAD_G4, 1'b0);
    load_sequence(GEN4);
    exp_seq.push_back(ZEROS);
    bring_up();
    disconnect_sbrx = 1'b1;
    while (os_sel != ZEROS)
      step_cycle();
    step_cycle();
    if (status.cl0 !== 1'b0)
    begin
      $display("[ERROR] %0t status_o.cl0 expected 0 got %b", $time, status.cl0);
      errors++;
    end
    lane_disable = 1'b1;
    while (!status.disabled)
      step_cycle();
    step_cycle();
    sequence_done();
    disconnect_sbrx = 1'b0;
    lane_disable    = 1'b0;
    report_test(5, "disconnect and disable", errs_before);
  endtask

  task run_timeout_test();
    int errs_before;
    errs_before = errors;
    reset_dut(CABLE_G4, PAYLOAD_G4, 1'b0);
    exp_seq.push_back(ZEROS);
    exp_seq.push_back(TS1_G4);
    exp_seq.push_back(TS2_G4);
    load_sequence(GEN4);   // retrain from parameter exchange
    disabled_min = 1'b1;
    while (!status.ts2_gen4)
      step_cycle();
    train_timeout = 1'b1;
    step_cycle();
    train_timeout = 1'b0;
    while (!status.cl0)
      step_cycle();
    step_cycle();
    if (req_at_data != 2)
    begin
      $display("[ERROR] %0t at_req_o rises before DATA expected 2 got %0d", $time, req_at_data);
      errors++;
    end
    sequence_done();
    report_test(6, "training timeout", errs_before);
  endtask

  initial
  begin
    reset_n         = 1'b0;
    lane_disable    = 1'b0;
    disabled_min    = 1'b0;
    disconnect_sbrx = 1'b0;
    new_sym         = 1'b1;
    train_timeout   = 1'b0;
    cable_word      = CABLE_G4;
    payload         = PAYLOAD_G4;
    err_first       = 1'b0;
    seed            = 32'h3def70d2;
    errors          = 0;
    failed_tests    = 0;
    cycle_cnt       = 0;
    sel_valid       = 1'b0;
    req_prev        = 1'b0;
    req_rises       = 0;
    req_at_data     = -1;

    run_reset_test();
    run_gen4_test();
    run_random_test();
    run_at_error_test();
    run_disconnect_test();
    run_timeout_test();

    $display("tests run: %0d, failing tests: %0d, errors: %0d", N_TESTS, failed_tests, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- tb_link_partner.sv
// link partner model that answers each four-phase request after ACK_DELAY cycles
// the first AT response carries an error when err_first_i is high during reset
module tb_link_partner
  import lane_init_pkg::*;
(
  input  logic         fsm_clk,
  input  logic         reset_n,
  input  logic [31:0]  cable_word_i,
  input  logic [23:0]  payload_i,
  input  logic         err_first_i,
  input  logic         cfg_req_i,
  input  logic         at_req_i,
  input  os_sel_e      os_sel_i,
  input  link_status_t status_i,
  output logic         cfg_ack_o,
  output logic [31:0]  cfg_rdata_o,
  output logic         at_ack_o,
  output logic         at_err_o,
  output logic [23:0]  at_payload_o,
  output logic         at_resp_sent_o,
  output logic         os_sent_o,
  output lane_rx_t     lane_rx_o
);

  localparam int ACK_DELAY  = 2;   // cycles from req seen to ack
  localparam int RESP_DELAY = 3;   // good AT ack to own response sent
  localparam int OS_PERIOD  = 3;   // one ordered set every 3 cycles

  logic in_reset;
  logic err_pending;
  int   cfg_wait;
  int   at_wait;
  int   resp_wait;
  int   os_phase;

  task idle_outputs();
    cfg_ack_o      = 1'b0;
    cfg_rdata_o    = '0;
    at_ack_o       = 1'b0;
    at_err_o       = 1'b0;
    at_payload_o   = '0;
    at_resp_sent_o = 1'b0;
    os_sent_o      = 1'b0;
    lane_rx_o      = '{lane1: ZEROS, lane0: ZEROS};
    cfg_wait       = 0;
    at_wait        = 0;
    resp_wait      = 0;
    os_phase       = 0;
  endtask

  initial
  begin
    err_pending = 1'b0;
    idle_outputs();
    forever
    begin
      @(posedge fsm_clk);
      in_reset = !reset_n;   // reset_n only moves at +2 so it is stable here
      #2;
      if (in_reset)
      begin
        idle_outputs();
        err_pending = err_first_i;
      end
      else
      begin
        ////////////////////////////////////////////////////////////////////////////
        // configuration space
        ////////////////////////////////////////////////////////////////////////////
        if (cfg_ack_o && !cfg_req_i)
        begin
          cfg_ack_o   = 1'b0;   // req gone, close the handshake
          cfg_rdata_o = '0;
        end
        else if (cfg_req_i && !cfg_ack_o)
        begin
          if (cfg_wait == ACK_DELAY)
          begin
            cfg_ack_o   = 1'b1;
            cfg_rdata_o = cable_word_i;
            cfg_wait    = 0;
          end
          else
            cfg_wait++;
        end

        ////////////////////////////////////////////////////////////////////////////
        // AT responder
        ////////////////////////////////////////////////////////////////////////////
        if (at_ack_o && !at_req_i)
        begin
          at_ack_o     = 1'b0;
          at_err_o     = 1'b0;
          at_payload_o = '0;
        end
        else if (at_req_i && !at_ack_o)
        begin
          at_resp_sent_o = 1'b0;   // new exchange, old response no longer counts
          if (at_wait == ACK_DELAY)
          begin
            at_ack_o     = 1'b1;
            at_err_o     = err_pending;
            at_payload_o = payload_i;
            resp_wait    = err_pending ? 0 : RESP_DELAY;
            err_pending  = 1'b0;
            at_wait      = 0;
          end
          else
            at_wait++;
        end
        if (resp_wait > 0)
        begin
          resp_wait--;
          if (resp_wait == 0)
            at_resp_sent_o = 1'b1;   // held until the next request
        end

        // transmit pacing and lane echo
        if (status_i.training)
        begin
          os_phase++;
          os_sent_o = (os_phase == OS_PERIOD);
          if (os_phase == OS_PERIOD)
            os_phase = 0;
        end
        else
        begin
          os_sent_o = 1'b0;
          os_phase  = 0;
        end
        lane_rx_o = '{lane1: os_sel_i, lane0: os_sel_i};
      end
    end
  end

endmodule

//--- lane_init_top.sv
// count targets must fit in CNT_W bits or the phase never completes
// one config read and one AT request in flight at a time, both four-phase req/ack
module lane_init_top
  import lane_init_pkg::*;
#(
  parameter int G4_TX_CNT     = 16,
  parameter int G4_RX_CNT     = 1,
  parameter int SLOS_TX_CNT   = 2,
  parameter int G23_RX_CNT    = 2,
  parameter int G3_TS1_TX_CNT = 16,
  parameter int G2_TS1_TX_CNT = 32,
  parameter int G3_TS2_TX_CNT = 8,
  parameter int G2_TS2_TX_CNT = 16
)
(
  input  logic         fsm_clk,
  input  logic         reset_n,
  input  logic         lane_disable_i,
  input  logic         disabled_min_i,
  input  logic         disconnect_sbrx_i,
  input  logic         new_sym_i,
  input  logic         train_timeout_i,
  input  logic         os_sent_i,
  input  logic         at_resp_sent_i,
  input  lane_rx_t     lane_rx_i,
  input  logic         cfg_ack_i,
  input  logic [31:0]  cfg_rdata_i,
  input  logic         at_ack_i,
  input  logic         at_err_i,
  input  logic [23:0]  at_payload_i,
  output logic         cfg_req_o,
  output logic [7:0]   cfg_addr_o,
  output logic         at_req_o,
  output os_sel_e      os_sel_o,
  output gen_speed_e   gen_speed_o,
  output link_status_t status_o
);

  localparam int CNT_W = 6;

  link_state_e state;
  logic        is_usb4;
  gen_speed_e  cable_gen;
  logic        at_done;
  gen_speed_e  gen_speed;
  logic        phase_done;

  assign gen_speed_o = gen_speed;

  link_state_fsm u_link_state_fsm (
    .fsm_clk           (fsm_clk),
    .reset_n           (reset_n),
    .lane_disable_i    (lane_disable_i),
    .disabled_min_i    (disabled_min_i),
    .disconnect_sbrx_i (disconnect_sbrx_i),
    .new_sym_i         (new_sym_i),
    .train_timeout_i   (train_timeout_i),
    .at_resp_sent_i    (at_resp_sent_i),
    .is_usb4_i         (is_usb4),
    .at_done_i         (at_done),
    .phase_done_i      (phase_done),
    .gen_speed_i       (gen_speed),
    .state_o           (state),
    .os_sel_o          (os_sel_o),
    .status_o          (status_o)
  );

  cable_prop_reader u_cable_prop_reader (
    .fsm_clk     (fsm_clk),
    .reset_n     (reset_n),
    .state_i     (state),
    .cfg_ack_i   (cfg_ack_i),
    .cfg_rdata_i (cfg_rdata_i),
    .cfg_req_o   (cfg_req_o),
    .cfg_addr_o  (cfg_addr_o),
    .is_usb4_o   (is_usb4),
    .cable_gen_o (cable_gen)
  );

  param_exchange u_param_exchange (
    .fsm_clk      (fsm_clk),
    .reset_n      (reset_n),
    .state_i      (state),
    .cable_gen_i  (cable_gen),
    .at_ack_i     (at_ack_i),
    .at_err_i     (at_err_i),
    .at_payload_i (at_payload_i),
    .at_req_o     (at_req_o),
    .at_done_o    (at_done),
    .gen_speed_o  (gen_speed)
  );

  training_os_counter #(
    .CNT_W         (CNT_W),
    .G4_TX_CNT     (G4_TX_CNT),
    .G4_RX_CNT     (G4_RX_CNT),
    .SLOS_TX_CNT   (SLOS_TX_CNT),
    .G23_RX_CNT    (G23_RX_CNT),
    .G3_TS1_TX_CNT (G3_TS1_TX_CNT),
    .G2_TS1_TX_CNT (G2_TS1_TX_CNT),
    .G3_TS2_TX_CNT (G3_TS2_TX_CNT),
    .G2_TS2_TX_CNT (G2_TS2_TX_CNT)
  ) u_training_os_counter (
    .fsm_clk      (fsm_clk),
    .reset_n      (reset_n),
    .state_i      (state),
    .gen_speed_i  (gen_speed),
    .os_sent_i    (os_sent_i),
    .lane_rx_i    (lane_rx_i),
    .phase_done_o (phase_done)
  );

endmodule

//--- training_os_counter.sv
// counts restart in the first cycle of every training state
// targets above 2**CNT_W-1 never complete
module training_os_counter
  import lane_init_pkg::*;
#(
  parameter int CNT_W         = 6,
  parameter int G4_TX_CNT     = 16,
  parameter int G4_RX_CNT     = 1,
  parameter int SLOS_TX_CNT   = 2,
  parameter int G23_RX_CNT    = 2,
  parameter int G3_TS1_TX_CNT = 16,
  parameter int G2_TS1_TX_CNT = 32,
  parameter int G3_TS2_TX_CNT = 8,
  parameter int G2_TS2_TX_CNT = 16
)
(
  input  logic        fsm_clk,
  input  logic        reset_n,
  input  link_state_e state_i,
  input  gen_speed_e  gen_speed_i,
  input  logic        os_sent_i,
  input  lane_rx_t    lane_rx_i,
  output logic        phase_done_o
);

  link_state_e      prev_state_q;
  logic             phase_start;
  os_sel_e          match_os;
  logic [CNT_W-1:0] tx_target;
  logic [CNT_W-1:0] rx_target;
  logic [CNT_W-1:0] tx_cnt_q;
  logic [CNT_W-1:0] rx0_cnt_q;
  logic [CNT_W-1:0] rx1_cnt_q;

  assign phase_start = (state_i != prev_state_q);

  ////////////////////////////////////////////////////////////////////////////
  // per-phase ordered set and targets
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    tx_target = CNT_W'(G4_TX_CNT);
    rx_target = CNT_W'(G4_RX_CNT);
    case (state_i)
      TRAINING_GEN2_3_SLOS1, TRAINING_GEN2_3_SLOS2:
      begin
        tx_target = CNT_W'(SLOS_TX_CNT);
        rx_target = CNT_W'(G23_RX_CNT);
      end
      TRAINING_GEN2_3_TS1:
      begin
        tx_target = (gen_speed_i == GEN3) ? CNT_W'(G3_TS1_TX_CNT) : CNT_W'(G2_TS1_TX_CNT);
        rx_target = CNT_W'(G23_RX_CNT);
      end
      TRAINING_GEN2_3_TS2:
      begin
        tx_target = (gen_speed_i == GEN3) ? CNT_W'(G3_TS2_TX_CNT) : CNT_W'(G2_TS2_TX_CNT);
        rx_target = CNT_W'(G23_RX_CNT);
      end
      default:
      begin
        tx_target = CNT_W'(G4_TX_CNT);   // gen 4 phases share one target pair
        rx_target = CNT_W'(G4_RX_CNT);
      end
    endcase
  end

  always_comb
  begin
    case (state_i)
      TRAINING_GEN4_TS1:     match_os = TS1_G4;
      TRAINING_GEN4_TS2:     match_os = TS2_G4;
      TRAINING_GEN4_TS3:     match_os = TS3_G4;
      TRAINING_GEN4_TS4:     match_os = TS4_G4;
      TRAINING_GEN2_3_SLOS1: match_os = SLOS1;
      TRAINING_GEN2_3_SLOS2: match_os = SLOS2;
      TRAINING_GEN2_3_TS1:   match_os = TS1_G23;
      TRAINING_GEN2_3_TS2:   match_os = TS2_G23;
      default:               match_os = ZEROS;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // saturating counters
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      prev_state_q <= DISABLED;
      tx_cnt_q     <= '0;
      rx0_cnt_q    <= '0;
      rx1_cnt_q    <= '0;
    end
    else
    begin
      prev_state_q <= state_i;
      if (phase_start || !is_training(state_i))
      begin
        tx_cnt_q  <= '0;
        rx0_cnt_q <= '0;
        rx1_cnt_q <= '0;
      end
      else
      begin
        if (os_sent_i && tx_cnt_q != tx_target)
          tx_cnt_q <= tx_cnt_q + CNT_W'(1);
        if (lane_rx_i.lane0 == match_os && rx0_cnt_q != rx_target)
          rx0_cnt_q <= rx0_cnt_q + CNT_W'(1);
        if (lane_rx_i.lane1 == match_os && rx1_cnt_q != rx_target)
          rx1_cnt_q <= rx1_cnt_q + CNT_W'(1);
      end
    end
  end

  // counts still hold the previous phase during phase_start
  assign phase_done_o = !phase_start && (tx_cnt_q == tx_target)
                        && (rx0_cnt_q == rx_target) && (rx1_cnt_q == rx_target);

endmodule

//--- param_exchange.sv
// one AT request per visit to CLD_PARAMETERS_1, repeated after an error response
// gen_speed holds its value until the link goes back to DISABLED
module param_exchange
  import lane_init_pkg::*;
(
  input  logic        fsm_clk,
  input  logic        reset_n,
  input  link_state_e state_i,
  input  gen_speed_e  cable_gen_i,
  input  logic        at_ack_i,
  input  logic        at_err_i,
  input  logic [23:0] at_payload_i,
  output logic        at_req_o,
  output logic        at_done_o,
  output gen_speed_e  gen_speed_o
);

  logic       at_req_q;
  logic       granted_q;   // good response taken in this visit
  logic       at_done_q;
  gen_speed_e gen_speed_q;
  gen_speed_e partner_gen;
  logic       ack_ok;

  assign ack_ok = at_req_q && at_ack_i && !at_err_i;

  // partner generation from the AT response payload
  always_comb
  begin
    if (at_payload_i[18])
      partner_gen = GEN4;
    else if (at_payload_i[13])
      partner_gen = GEN3;
    else
      partner_gen = GEN2;
  end

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      at_req_q    <= 1'b0;
      granted_q   <= 1'b0;
      at_done_q   <= 1'b0;
      gen_speed_q <= GEN4;
    end
    else
    begin
      at_done_q <= 1'b0;
      if (at_req_q && at_ack_i)
        at_req_q <= 1'b0;
      else if (state_i == CLD_PARAMETERS_1 && !granted_q && !at_ack_i)
        at_req_q <= 1'b1;
      if (state_i != CLD_PARAMETERS_1)
        granted_q <= 1'b0;
      else if (ack_ok)
      begin
        granted_q   <= 1'b1;
        at_done_q   <= 1'b1;
        // slower side wins, larger code is slower
        gen_speed_q <= (partner_gen > cable_gen_i) ? partner_gen : cable_gen_i;
      end
      if (state_i == DISABLED)
        gen_speed_q <= GEN4;
    end
  end

  assign at_req_o    = at_req_q;
  assign at_done_o   = at_done_q;
  assign gen_speed_o = gen_speed_q;

  a_at_req_held: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    at_req_o && !at_ack_i |=> at_req_o);

endmodule

//--- cable_prop_reader.sv
// cable properties word sits at config address 18
// a non-USB4 cable is re-read for as long as the FSM stays in CLD_CABLE_PROP
module cable_prop_reader
  import lane_init_pkg::*;
(
  input  logic        fsm_clk,
  input  logic        reset_n,
  input  link_state_e state_i,
  input  logic        cfg_ack_i,
  input  logic [31:0] cfg_rdata_i,
  output logic        cfg_req_o,
  output logic [7:0]  cfg_addr_o,
  output logic        is_usb4_o,
  output gen_speed_e  cable_gen_o
);

  localparam logic [7:0] CABLE_PROP_ADDR = 8'd18;
  localparam logic [7:0] USB4_ID         = 8'h40;

  logic       cfg_req_q;
  logic       is_usb4_q;
  gen_speed_e cable_gen_q;

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      cfg_req_q   <= 1'b0;
      is_usb4_q   <= 1'b0;
      cable_gen_q <= GEN4;
    end
    else
    begin
      if (cfg_req_q && cfg_ack_i)
      begin
        cfg_req_q <= 1'b0;   // data valid now, drop req
        is_usb4_q <= (cfg_rdata_i[7:0] == USB4_ID);
        if (cfg_rdata_i[21])
          cable_gen_q <= GEN4;
        else if (cfg_rdata_i[20])
          cable_gen_q <= GEN3;
        else
          cable_gen_q <= GEN2;
      end
      else if (state_i == CLD_CABLE_PROP && !is_usb4_q && !cfg_ack_i)
        cfg_req_q <= 1'b1;   // previous ack must be low first
      if (state_i == DISABLED)
      begin
        is_usb4_q   <= 1'b0;
        cable_gen_q <= GEN4;
      end
    end
  end

  assign cfg_req_o   = cfg_req_q;
  assign cfg_addr_o  = CABLE_PROP_ADDR;
  assign is_usb4_o   = is_usb4_q;
  assign cable_gen_o = cable_gen_q;

  a_cfg_req_after_ack_low: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    $rose(cfg_req_o) |-> !cfg_ack_i);

endmodule

//--- link_state_fsm.sv
// lane select and status lag the state by one cycle
// lane_disable_i wins over everything, then disconnect, then the training timeout
module link_state_fsm
  import lane_init_pkg::*;
(
  input  logic         fsm_clk,
  input  logic         reset_n,
  input  logic         lane_disable_i,
  input  logic         disabled_min_i,
  input  logic         disconnect_sbrx_i,
  input  logic         new_sym_i,
  input  logic         train_timeout_i,
  input  logic         at_resp_sent_i,
  input  logic         is_usb4_i,
  input  logic         at_done_i,
  input  logic         phase_done_i,
  input  gen_speed_e   gen_speed_i,
  output link_state_e  state_o,
  output os_sel_e      os_sel_o,
  output link_status_t status_o
);

  link_state_e  state_q;
  link_state_e  state_d;
  os_sel_e      os_sel_q;
  link_status_t status_q;
  logic         sb_disconnect;

  // disconnect is ignored until the cable has been identified
  assign sb_disconnect = disconnect_sbrx_i && (state_q != DISABLED)
                         && (state_q != CLD_CABLE_PROP);

  ////////////////////////////////////////////////////////////////////////////
  // state register and next state
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
      state_q <= DISABLED;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    if (lane_disable_i)
      state_d = DISABLED;
    else if (sb_disconnect)
      state_d = CLD_DET_DEVICE;
    else if (train_timeout_i && is_training(state_q))
      state_d = CLD_PARAMETERS_1;   // back to parameter exchange
    else
    begin
      case (state_q)
        DISABLED:
          if (disabled_min_i)
            state_d = CLD_CABLE_PROP;
        CLD_CABLE_PROP:
          if (is_usb4_i)
            state_d = CLD_DET_DEVICE;
        CLD_DET_DEVICE:
          state_d = CLD_PARAMETERS_1;   // disconnect already cleared here
        CLD_PARAMETERS_1:
          if (at_done_i)
            state_d = CLD_PARAMETERS_2;
        CLD_PARAMETERS_2:
          if (at_resp_sent_i)
            state_d = CLD_CLK_SWITCH;
        CLD_CLK_SWITCH:
          if (new_sym_i)
            state_d = (gen_speed_i == GEN4) ? TRAINING_GEN4_TS1 : TRAINING_GEN2_3_SLOS1;
        TRAINING_GEN4_TS1:
          if (phase_done_i)
            state_d = TRAINING_GEN4_TS2;
        TRAINING_GEN4_TS2:
          if (phase_done_i)
            state_d = TRAINING_GEN4_TS3;
        TRAINING_GEN4_TS3:
          if (phase_done_i)
            state_d = TRAINING_GEN4_TS4;
        TRAINING_GEN4_TS4:
          if (phase_done_i && new_sym_i)
            state_d = CL0;
        TRAINING_GEN2_3_SLOS1:
          if (phase_done_i)
            state_d = TRAINING_GEN2_3_SLOS2;
        TRAINING_GEN2_3_SLOS2:
          if (phase_done_i)
            state_d = TRAINING_GEN2_3_TS1;
        TRAINING_GEN2_3_TS1:
          if (phase_done_i)
            state_d = TRAINING_GEN2_3_TS2;
        TRAINING_GEN2_3_TS2:
          if (phase_done_i && new_sym_i)
            state_d = CL0;
        CL0:
          state_d = CL0;   // leaves only on disable or disconnect
        default:
          state_d = DISABLED;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registered lane select and status flags
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      os_sel_q <= ZEROS;
      status_q <= '{disabled: 1'b1, default: 1'b0};
    end
    else
    begin
      case (state_q)
        TRAINING_GEN4_TS1:     os_sel_q <= TS1_G4;
        TRAINING_GEN4_TS2:     os_sel_q <= TS2_G4;
        TRAINING_GEN4_TS3:     os_sel_q <= TS3_G4;
        TRAINING_GEN4_TS4:     os_sel_q <= TS4_G4;
        TRAINING_GEN2_3_SLOS1: os_sel_q <= SLOS1;
        TRAINING_GEN2_3_SLOS2: os_sel_q <= SLOS2;
        TRAINING_GEN2_3_TS1:   os_sel_q <= TS1_G23;
        TRAINING_GEN2_3_TS2:   os_sel_q <= TS2_G23;
        CL0:                   os_sel_q <= DATA;
        default:               os_sel_q <= ZEROS;   // disabled and CLd
      endcase
      status_q.disabled <= (state_q == DISABLED);
      status_q.training <= is_training(state_q);
      status_q.ts1_gen4 <= (state_q == TRAINING_GEN4_TS1);
      status_q.ts2_gen4 <= (state_q == TRAINING_GEN4_TS2);
      status_q.cl0      <= (state_q == CL0);
    end
  end

  assign state_o  = state_q;
  assign os_sel_o = os_sel_q;
  assign status_o = status_q;

  // encoding 4'hf is unused
  a_state_legal: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    !$isunknown(state_q) && (state_q <= CL0));

endmodule

//--- lane_init_pkg.sv
// shared types for the lane initialization controller
// is_training relies on contiguous state codes for the training states
package lane_init_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // controller states
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    DISABLED              = 4'd0,
    CLD_CABLE_PROP        = 4'd1,   // read cable properties word
    CLD_DET_DEVICE        = 4'd2,   // wait for sideband disconnect to clear
    CLD_PARAMETERS_1      = 4'd3,   // AT request for partner parameters
    CLD_PARAMETERS_2      = 4'd4,   // wait for own AT response to go out
    CLD_CLK_SWITCH        = 4'd5,   // wait for new symbol
    TRAINING_GEN4_TS1     = 4'd6,
    TRAINING_GEN4_TS2     = 4'd7,
    TRAINING_GEN4_TS3     = 4'd8,
    TRAINING_GEN4_TS4     = 4'd9,
    TRAINING_GEN2_3_SLOS1 = 4'd10,
    TRAINING_GEN2_3_SLOS2 = 4'd11,
    TRAINING_GEN2_3_TS1   = 4'd12,
    TRAINING_GEN2_3_TS2   = 4'd13,
    CL0                   = 4'd14   // link up, transport data
  } link_state_e;

  // lower speed carries the larger code
  typedef enum logic [1:0] {
    GEN4 = 2'd0,
    GEN3 = 2'd1,
    GEN2 = 2'd2
  } gen_speed_e;

  // lane content select and the code reported by the receive lanes
  typedef enum logic [3:0] {
    SLOS1   = 4'd0,
    SLOS2   = 4'd1,
    TS1_G23 = 4'd2,
    TS2_G23 = 4'd3,
    TS1_G4  = 4'd4,
    TS2_G4  = 4'd5,
    TS3_G4  = 4'd6,
    TS4_G4  = 4'd7,
    DATA    = 4'd8,
    ZEROS   = 4'd9
  } os_sel_e;

  typedef struct packed {
    os_sel_e lane1;
    os_sel_e lane0;
  } lane_rx_t;

  typedef struct packed {
    logic disabled;
    logic training;
    logic ts1_gen4;   // sending gen 4 TS1
    logic ts2_gen4;   // sending gen 4 TS2
    logic cl0;
  } link_status_t;

  // true for the eight training states, gen 4 and gen 2/3 alike
  function automatic logic is_training(input link_state_e st);
    return (st >= TRAINING_GEN4_TS1) && (st <= TRAINING_GEN2_3_TS2);
  endfunction

endpackage
